// File: flist.f
+incdir+test
design/udma_rx_pkg.sv
design/udma_rx_arbiter.sv
design/udma_rx_addrgen.sv
design/udma_rx_fifo.sv
design/udma_rx_ctrl.sv
design/udma_rx_l2_format.sv
design/udma_rx_channels.sv
test/tb_udma_rx_channels.sv

// File: Bender.yml
package:
  name: udma_rx

sources:
  # rtl in dependency order
  - design/udma_rx_pkg.sv
  - design/udma_rx_arbiter.sv
  - design/udma_rx_addrgen.sv
  - design/udma_rx_fifo.sv
  - design/udma_rx_ctrl.sv
  - design/udma_rx_l2_format.sv
  - design/udma_rx_channels.sv

  - target: test
    include_dirs:
      - test
    files:
      - test/tb_udma_rx_channels.sv

// File: test/tb_udma_rx_ref.svh
`ifndef TB_UDMA_RX_REF_SVH
`define TB_UDMA_RX_REF_SVH

// one bus beat as {address, byte enables, write data}
typedef logic [67:0] beat_t;

beat_t exp_q [4][$];    // expected beats per channel, in acceptance order
int    total_beats = 0;

// full bus address of a word inside its destination region
function automatic bus_addr_t region_addr(addr_t a, dest_t dest, prefix_t pfx);
    bus_addr_t full;
    full = {{(32-L2_AWIDTH){1'b0}}, a};
    case (dest)
        2'd0:    full[31:24] = 8'h1C;
        2'd1:    full[31:20] = 12'h1A1;
        2'd2:    full[31:24] = 8'h10;
        default: full[31:L2_AWIDTH] = pfx;
    endcase
    return full;
endfunction

// byte j of the word lands at address a+j, a beat keeps the bytes of its own word
function automatic beat_t expected_beat(addr_t a, int k, dest_t dest, data_t d,
                                        bit second, prefix_t pfx);
    addr_t word_a;
    addr_t b;
    be_t   be;
    data_t wd;
    word_a = {a[L2_AWIDTH-1:2], 2'b00};
    if (second)
        word_a = word_a + addr_t'(4);
    be = '0;
    wd = '0;
    for (int j = 0; j < k; j++)
    begin
        b = a + addr_t'(j);
        if ({b[L2_AWIDTH-1:2], 2'b00} == word_a)
        begin
            be[b[1:0]]                  = 1'b1;
            wd[int'(b[1:0])*8 +: 8]     = d[j*8 +: 8];
        end
    end
    return {region_addr(word_a, dest, pfx), be, wd};
endfunction

// queue the beats of one accepted word
task automatic push_expected(int c, addr_t a, int k, dest_t dest, data_t d, prefix_t pfx);
    addr_t last;
    last = a + addr_t'(k - 1);
    exp_q[c].push_back(expected_beat(a, k, dest, d, 1'b0, pfx));
    total_beats++;
    if (last[L2_AWIDTH-1:2] != a[L2_AWIDTH-1:2])  // spills into the next word
    begin
        exp_q[c].push_back(expected_beat(a, k, dest, d, 1'b1, pfx));
        total_beats++;
    end
endtask

`endif

// File: test/tb_udma_rx_channels.sv
`default_nettype none
`timescale 1ns/100ps

module tb_udma_rx_channels
    import udma_rx_pkg::*;
();

    localparam int N_CH       = 4;
    localparam int FIFO_DEPTH = 4;

    logic                    clk_i = 1'b0;
    logic                    rstn_i;
    addr_t       [N_CH-1:0]  cfg_startaddr_i;
    trans_size_t [N_CH-1:0]  cfg_size_i;
    dest_t       [N_CH-1:0]  cfg_dest_i;
    logic        [N_CH-1:0]  cfg_en_i;
    logic        [N_CH-1:0]  ch_valid_i;
    data_t       [N_CH-1:0]  ch_data_i;
    dsize_t      [N_CH-1:0]  ch_datasize_i;
    logic        [N_CH-1:0]  ch_ready_o;
    logic        [N_CH-1:0]  ch_eot_o;
    logic                    l2_req_o;
    logic                    l2_gnt_i;
    bus_addr_t               l2_addr_o;
    be_t                     l2_be_o;
    data_t                   l2_wdata_o;
    prefix_t                 l2_dest_i;

    integer seed = 45;
    string  test_name = "reset";
    int     cycles = 0;
    int     eot_cnt [N_CH];
    int     eot_exp [N_CH];
    int     waits [N_CH];     // other grants since this channel's last handshake
    int     stall_hs = 0;
    int     low_run = 0;
    logic   hold_gnt = 1'b0;

    `include "tb_udma_rx_ref.svh"

    udma_rx_channels #(
        .N_CHANNELS ( N_CH )
    ) udma_rx_channels_inst (
        .clk_i           ( clk_i           ),
        .rstn_i          ( rstn_i          ),
        .cfg_startaddr_i ( cfg_startaddr_i ),
        .cfg_size_i      ( cfg_size_i      ),
        .cfg_dest_i      ( cfg_dest_i      ),
        .cfg_en_i        ( cfg_en_i        ),
        .ch_valid_i      ( ch_valid_i      ),
        .ch_data_i       ( ch_data_i       ),
        .ch_datasize_i   ( ch_datasize_i   ),
        .ch_ready_o      ( ch_ready_o      ),
        .ch_eot_o        ( ch_eot_o        ),
        .l2_req_o        ( l2_req_o        ),
        .l2_gnt_i        ( l2_gnt_i        ),
        .l2_addr_o       ( l2_addr_o       ),
        .l2_be_o         ( l2_be_o         ),
        .l2_wdata_o      ( l2_wdata_o      ),
        .l2_dest_i       ( l2_dest_i       )
    );

    initial
    begin
        forever #5 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic stop_on_error(string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual)
            stop_on_error($sformatf("Mismatch %s: expected %h, actual %h", name, expected,
                                    actual));
    endtask

    function automatic data_t lane_mask(be_t be);
        data_t m;
        for (int i = 0; i < 4; i++)
            m[i*8 +: 8] = {8{be[i]}};
        return m;
    endfunction

    // configure one channel, then feed it words until the byte count is used up
    task automatic run_transfer(int c, addr_t start, int bytes, dsize_t ds, dest_t dest);
        addr_t a;
        int    rem;
        int    k;
        int    gap;
        data_t d;
        a   = start;
        rem = bytes;
        @(negedge clk_i);
        cfg_startaddr_i[c] = start;
        cfg_size_i[c]      = trans_size_t'(bytes);
        cfg_dest_i[c]      = dest;
        ch_datasize_i[c]   = ds;
        cfg_en_i[c]        = 1'b1;
        eot_exp[c]++;
        @(negedge clk_i);
        cfg_en_i[c] = 1'b0;
        while (rem != 0)
        begin
            gap = $unsigned($random(seed)) % 3;
            if (gap != 0)
            begin
                ch_valid_i[c] = 1'b0;
                repeat (gap) @(negedge clk_i);
            end
            d             = $random(seed);
            ch_valid_i[c] = 1'b1;
            ch_data_i[c]  = d;
            @(posedge clk_i);
            while (!ch_ready_o[c])
                @(posedge clk_i);
            k = (rem < (1 << ds)) ? rem : (1 << ds);  // last word may be short
            push_expected(c, a, k, dest, d, l2_dest_i);
            a   = a + addr_t'(k);
            rem = rem - k;
            @(negedge clk_i);
        end
        ch_valid_i[c] = 1'b0;
        @(posedge clk_i);
        check_value($sformatf("%s eot ch%0d", test_name, c), 32'd1, 32'(ch_eot_o[c]));
    endtask

    task automatic random_transfers(int c);
        addr_t  start;
        dsize_t ds;
        int     bytes;
        for (int t = 0; t < 2; t++)
        begin
            ds    = dsize_t'($unsigned($random(seed)) % 3);
            bytes = 20 + $unsigned($random(seed)) % 21;
            start = addr_t'((c << 12) + 'h400 + t * 'h100 + $unsigned($random(seed)) % 4);
            run_transfer(c, start, bytes, ds, dest_t'(c));
        end
    endtask

    task automatic stall_bus(int cycles_low);
        repeat (20) @(negedge clk_i);
        hold_gnt <= 1'b1;
        stall_hs = 0;
        repeat (cycles_low) @(posedge clk_i);
        check_value({test_name, " ready while stalled"}, 32'd0, 32'(ch_ready_o));
        if (stall_hs > FIFO_DEPTH + 2)
            stop_on_error($sformatf("%0d handshakes accepted while the bus was stalled",
                                    stall_hs));
        @(negedge clk_i);
        hold_gnt <= 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size() != 0)
            @(posedge clk_i);
        repeat (4) @(posedge clk_i);
        for (int c = 0; c < N_CH; c++)
            check_value($sformatf("%s eot count ch%0d", test_name, c), eot_exp[c], eot_cnt[c]);
    endtask

    //////////////////////////////////////////////////////////////////////
    // memory slave and monitors
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk_i)
    begin
        if (hold_gnt)
            l2_gnt_i = 1'b0;
        else if (low_run >= 5)
            l2_gnt_i = 1'b1;   // cap a random low stretch
        else
            l2_gnt_i = ($unsigned($random(seed)) % 3) != 0;
        low_run = l2_gnt_i ? 0 : low_run + 1;
    end

    always @(posedge clk_i)
    begin : monitor
        beat_t           want;
        int              owner;
        logic [N_CH-1:0] hs;
        cycles++;
        if (cycles > 40 * total_beats + 500)
            stop_on_error($sformatf("timeout after %0d cycles in %s", cycles, test_name));
        if (rstn_i)
        begin
            hs = ch_valid_i & ch_ready_o;
            if (hold_gnt && hs != '0)
                stall_hs++;
            for (int c = 0; c < N_CH; c++)
            begin
                if (ch_eot_o[c])
                    eot_cnt[c]++;
                if (hs[c])
                    waits[c] = 0;
                else if (ch_valid_i[c] && hs != '0)
                    waits[c]++;
                if (waits[c] > N_CH - 1)
                    stop_on_error($sformatf("channel %0d passed over by %0d grants", c,
                                            waits[c]));
            end
            if (l2_req_o && l2_gnt_i)
            begin
                owner = int'(l2_addr_o[13:12]);  // channels own disjoint 4k windows
                if (exp_q[owner].size() == 0)
                    stop_on_error($sformatf("unexpected bus write to %h", l2_addr_o));
                else
                begin
                    want = exp_q[owner].pop_front();
                    check_value({test_name, " address"}, want[67:36], l2_addr_o);
                    check_value({test_name, " byte enables"}, 32'(want[35:32]), 32'(l2_be_o));
                    check_value({test_name, " data"}, want[31:0],
                                l2_wdata_o & lane_mask(l2_be_o));
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        rstn_i          = 1'b0;
        cfg_startaddr_i = '0;
        cfg_size_i      = '0;
        cfg_dest_i      = '0;
        cfg_en_i        = '0;
        ch_valid_i      = '0;
        ch_data_i       = '0;
        ch_datasize_i   = '0;
        l2_gnt_i        = 1'b0;
        l2_dest_i       = '0;
        repeat (16) @(negedge clk_i);
        rstn_i = 1'b1;
        @(posedge clk_i);
        check_value("reset", 32'd0, 32'({l2_req_o, ch_ready_o, ch_eot_o}));

        test_name = "aligned_words";
        run_transfer(0, 16'h0000, 32, 2'd2, 2'd0);
        wait_drained();

        test_name = "byte_half_lanes";
        fork
            begin
                run_transfer(1, 16'h1001, 7, 2'd0, 2'd1);
                run_transfer(1, 16'h1100, 8, 2'd1, 2'd1);
            end
            run_transfer(2, 16'h2001, 10, 2'd1, 2'd2);
        join
        wait_drained();

        test_name = "crossing_region3";
        @(negedge clk_i);
        l2_dest_i = prefix_t'($random(seed));
        run_transfer(3, 16'h3001, 12, 2'd2, 2'd3);
        run_transfer(3, 16'h3102, 8, 2'd2, 2'd3);
        run_transfer(3, 16'h3203, 6, 2'd1, 2'd3);
        wait_drained();

        test_name = "truncated_last";
        fork
            run_transfer(0, 16'h0102, 7, 2'd2, 2'd0);
            run_transfer(1, 16'h1201, 5, 2'd1, 2'd1);
            run_transfer(2, 16'h2300, 6, 2'd2, 2'd2);
        join
        wait_drained();

        test_name = "all_channels";
        fork
            random_transfers(0);
            random_transfers(1);
            random_transfers(2);
            random_transfers(3);
        join
        wait_drained();

        test_name = "back_pressure";
        fork
            run_transfer(0, 16'h0800, 64, 2'd2, 2'd0);
            run_transfer(1, 16'h1800, 64, 2'd2, 2'd1);
            run_transfer(2, 16'h2800, 64, 2'd2, 2'd2);
            run_transfer(3, 16'h3800, 64, 2'd2, 2'd3);
            stall_bus(50);
        join
        wait_drained();

        // every expected beat is gone, so no request may be left on the bus
        if (l2_req_o)
            stop_on_error("bus request still pending after all transfers drained");
        else
        begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: design/udma_rx_channels.sv
`default_nettype none
`timescale 1ns/100ps

module udma_rx_channels
    import udma_rx_pkg::*;
#(
    parameter int N_CHANNELS = 4
)
(
    input  wire logic                         clk_i,
    input  wire logic                         rstn_i,

    // channel configuration
    input  wire addr_t       [N_CHANNELS-1:0] cfg_startaddr_i,
    input  wire trans_size_t [N_CHANNELS-1:0] cfg_size_i,
    input  wire dest_t       [N_CHANNELS-1:0] cfg_dest_i,
    input  wire logic        [N_CHANNELS-1:0] cfg_en_i,

    // channel data
    input  wire logic        [N_CHANNELS-1:0] ch_valid_i,
    input  wire data_t       [N_CHANNELS-1:0] ch_data_i,
    input  wire dsize_t      [N_CHANNELS-1:0] ch_datasize_i,
    output logic             [N_CHANNELS-1:0] ch_ready_o,
    output logic             [N_CHANNELS-1:0] ch_eot_o,

    // memory bus
    output logic                              l2_req_o,
    input  wire logic                         l2_gnt_i,
    output bus_addr_t                         l2_addr_o,
    output be_t                               l2_be_o,
    output data_t                             l2_wdata_o,
    input  wire prefix_t                      l2_dest_i
);

    logic    [N_CHANNELS-1:0] s_active;
    logic    [N_CHANNELS-1:0] s_req;
    logic    [N_CHANNELS-1:0] s_grant;
    logic                     s_any_grant;
    logic                     s_sample;
    addr_t   [N_CHANNELS-1:0] s_curr_addr;
    nbytes_t [N_CHANNELS-1:0] s_nbytes;

    logic                     s_push;
    logic    [RX_ENTRY_W-1:0] s_push_data;
    logic                     s_pop;
    logic                     s_fifo_full;
    logic                     s_fifo_valid;
    logic    [RX_ENTRY_W-1:0] s_fifo_data;

    dest_t                    s_l2_dest;
    nbytes_t                  s_l2_nbytes;
    addr_t                    s_l2_addr;
    data_t                    s_l2_data;
    logic                     s_cross;
    logic                     s_second;

    assign s_req = ch_valid_i & s_active;
    assign {s_l2_dest, s_l2_nbytes, s_l2_addr, s_l2_data} = s_fifo_data;

    udma_rx_arbiter #(
        .N_CHANNELS ( N_CHANNELS )
    ) u_arbiter (
        .clk_i       ( clk_i       ),
        .rstn_i      ( rstn_i      ),
        .req_i       ( s_req       ),
        .ack_i       ( s_sample    ),
        .grant_o     ( s_grant     ),
        .any_grant_o ( s_any_grant )
    );

    for (genvar c = 0; c < N_CHANNELS; c++)
    begin : g_addrgen
        udma_rx_addrgen u_addrgen (
            .clk_i           ( clk_i              ),
            .rstn_i          ( rstn_i             ),
            .cfg_startaddr_i ( cfg_startaddr_i[c] ),
            .cfg_size_i      ( cfg_size_i[c]      ),
            .cfg_en_i        ( cfg_en_i[c]        ),
            .datasize_i      ( ch_datasize_i[c]   ),
            .take_i          ( ch_ready_o[c]      ),  // ready only on the granted channel
            .curr_addr_o     ( s_curr_addr[c]     ),
            .nbytes_o        ( s_nbytes[c]        ),
            .active_o        ( s_active[c]        ),
            .eot_o           ( ch_eot_o[c]        )
        );
    end

    udma_rx_ctrl #(
        .N_CHANNELS ( N_CHANNELS )
    ) u_ctrl (
        .clk_i         ( clk_i         ),
        .rstn_i        ( rstn_i        ),
        .grant_i       ( s_grant       ),
        .any_grant_i   ( s_any_grant   ),
        .ch_data_i     ( ch_data_i     ),
        .ch_datasize_i ( ch_datasize_i ),
        .ch_addr_i     ( s_curr_addr   ),
        .ch_nbytes_i   ( s_nbytes      ),
        .ch_dest_i     ( cfg_dest_i    ),
        .fifo_full_i   ( s_fifo_full   ),
        .fifo_valid_i  ( s_fifo_valid  ),
        .cross_i       ( s_cross       ),
        .l2_gnt_i      ( l2_gnt_i      ),
        .sample_o      ( s_sample      ),
        .ch_ready_o    ( ch_ready_o    ),
        .push_o        ( s_push        ),
        .push_data_o   ( s_push_data   ),
        .fifo_pop_o    ( s_pop         ),
        .second_o      ( s_second      ),
        .l2_req_o      ( l2_req_o      )
    );

    udma_rx_fifo #(
        .WIDTH      ( RX_ENTRY_W ),
        .FIFO_DEPTH ( 4          )
    ) u_fifo (
        .clk_i   ( clk_i        ),
        .rstn_i  ( rstn_i       ),
        .push_i  ( s_push       ),
        .data_i  ( s_push_data  ),
        .pop_i   ( s_pop        ),
        .full_o  ( s_fifo_full  ),
        .valid_o ( s_fifo_valid ),
        .data_o  ( s_fifo_data  )
    );

    udma_rx_l2_format u_l2_format (
        .addr_i     ( s_l2_addr   ),
        .nbytes_i   ( s_l2_nbytes ),
        .dest_i     ( s_l2_dest   ),
        .data_i     ( s_l2_data   ),
        .second_i   ( s_second    ),
        .l2_dest_i  ( l2_dest_i   ),
        .cross_o    ( s_cross     ),
        .l2_addr_o  ( l2_addr_o   ),
        .l2_be_o    ( l2_be_o     ),
        .l2_wdata_o ( l2_wdata_o  )
    );

endmodule

`default_nettype wire

// File: design/udma_rx_l2_format.sv
`default_nettype none
`timescale 1ns/100ps

module udma_rx_l2_format
    import udma_rx_pkg::*;
(
    input  wire addr_t   addr_i,
    input  wire nbytes_t nbytes_i,
    input  wire dest_t   dest_i,
    input  wire data_t   data_i,
    input  wire logic    second_i,
    input  wire prefix_t l2_dest_i,
    output logic         cross_o,
    output bus_addr_t    l2_addr_o,
    output be_t          l2_be_o,
    output data_t        l2_wdata_o
);

    logic [1:0]           s_offset;     // lane of the first byte
    logic [2:0]           s_k;          // bytes in the entry
    logic [7:0]           s_be_span;    // enables over two words
    logic [63:0]          s_data_span;
    logic [L2_AWIDTH-3:0] s_word;

    assign s_offset = addr_i[1:0];
    assign s_k      = {1'b0, nbytes_i} + 3'd1;
    assign cross_o  = ({1'b0, s_offset} + s_k) > 3'd4;

    // place the entry across two words, the beat picks its half
    assign s_be_span   = (8'h0F >> (3'd4 - s_k)) << s_offset;
    assign s_data_span = {32'h0, data_i} << {s_offset, 3'b000};

    assign l2_be_o    = second_i ? s_be_span[7:4] : s_be_span[3:0];
    assign l2_wdata_o = second_i ? s_data_span[63:32] : s_data_span[31:0];

    // second beat goes to the following word
    assign s_word = addr_i[L2_AWIDTH-1:2] + (L2_AWIDTH-2)'(second_i);

    //////////////////////////////////////////////////////////////////////
    // region prefix
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        l2_addr_o = {{(32-L2_AWIDTH){1'b0}}, s_word, 2'b00};
        case (dest_i)
            2'd0:    l2_addr_o[31:24] = PREFIX_L2;
            2'd1:    l2_addr_o[31:20] = PREFIX_PERIPH;
            2'd2:    l2_addr_o[31:24] = PREFIX_CLUSTER;
            default: l2_addr_o[31:L2_AWIDTH] = l2_dest_i;  // set by software
        endcase
    end

endmodule

`default_nettype wire

// File: design/udma_rx_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

module udma_rx_ctrl
    import udma_rx_pkg::*;
#(
    parameter int N_CHANNELS = 4
)
(
    input  wire logic                      clk_i,
    input  wire logic                      rstn_i,
    input  wire logic     [N_CHANNELS-1:0] grant_i,
    input  wire logic                      any_grant_i,
    input  wire data_t    [N_CHANNELS-1:0] ch_data_i,
    input  wire dsize_t   [N_CHANNELS-1:0] ch_datasize_i,
    input  wire addr_t    [N_CHANNELS-1:0] ch_addr_i,
    input  wire nbytes_t  [N_CHANNELS-1:0] ch_nbytes_i,
    input  wire dest_t    [N_CHANNELS-1:0] ch_dest_i,
    input  wire logic                      fifo_full_i,
    input  wire logic                      fifo_valid_i,
    input  wire logic                      cross_i,
    input  wire logic                      l2_gnt_i,
    output logic                           sample_o,
    output logic          [N_CHANNELS-1:0] ch_ready_o,
    output logic                           push_o,
    output logic          [RX_ENTRY_W-1:0] push_data_o,
    output logic                           fifo_pop_o,
    output logic                           second_o,
    output logic                           l2_req_o
);

    data_t     s_data;
    dsize_t    s_size;
    addr_t     s_addr;
    nbytes_t   s_nbytes;
    dest_t     s_dest;

    // sampling register
    logic      r_valid;
    data_t     r_data;
    addr_t     r_addr;
    nbytes_t   r_nbytes;
    dest_t     r_dest;

    rx_state_e r_state;
    rx_state_e s_state_next;
    logic      s_pop;
    logic      s_push_ok;
    logic      s_room;

    //////////////////////////////////////////////////////////////////////
    // input mux and sampling
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        s_data   = '0;
        s_size   = '0;
        s_addr   = '0;
        s_nbytes = '0;
        s_dest   = '0;
        for (int i = 0; i < N_CHANNELS; i++)
        begin
            if (grant_i[i])
            begin
                s_data   = ch_data_i[i];
                s_size   = ch_datasize_i[i];
                s_addr   = ch_addr_i[i];
                s_nbytes = ch_nbytes_i[i];
                s_dest   = ch_dest_i[i];
            end
        end
    end

    assign s_push_ok  = !fifo_full_i || s_pop;
    assign s_room     = !r_valid || s_push_ok;  // register free next edge
    assign sample_o   = any_grant_i && s_room;
    assign ch_ready_o = grant_i & {N_CHANNELS{s_room}};

    assign push_o      = r_valid && s_push_ok;
    assign push_data_o = {r_dest, r_nbytes, r_addr, r_data};

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            r_valid <= 1'b0;
        else if (s_room)
            r_valid <= any_grant_i;
    end

    always_ff @(posedge clk_i)
    begin
        if (sample_o)
        begin
            case (s_size)  // drop lanes above the word size
                2'd0:    r_data <= {24'h0, s_data[7:0]};
                2'd1:    r_data <= {16'h0, s_data[15:0]};
                default: r_data <= s_data;
            endcase
            r_addr   <= s_addr;
            r_nbytes <= s_nbytes;
            r_dest   <= s_dest;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // bus side, split of crossing entries
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        s_state_next = r_state;
        s_pop        = 1'b0;
        case (r_state)
            RX_IDLE:
            begin
                if (fifo_valid_i && cross_i)
                begin
                    if (l2_gnt_i)
                        s_state_next = RX_NON_ALIGNED;  // low half done
                end
                else
                    s_pop = fifo_valid_i && l2_gnt_i;
            end
            RX_NON_ALIGNED:
            begin
                s_pop = l2_gnt_i;
                if (l2_gnt_i)
                    s_state_next = RX_IDLE;
            end
            default: s_state_next = RX_IDLE;
        endcase
    end

    assign fifo_pop_o = s_pop;
    assign second_o   = (r_state == RX_NON_ALIGNED);
    assign l2_req_o   = fifo_valid_i;

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            r_state <= RX_IDLE;
        else
            r_state <= s_state_next;
    end

endmodule

`default_nettype wire

// File: design/udma_rx_fifo.sv
`default_nettype none
`timescale 1ns/100ps

module udma_rx_fifo
#(
    parameter int WIDTH      = 32,
    parameter int FIFO_DEPTH = 4
)
(
    input  wire logic             clk_i,
    input  wire logic             rstn_i,
    input  wire logic             push_i,
    input  wire logic [WIDTH-1:0] data_i,
    input  wire logic             pop_i,
    output logic                  full_o,
    output logic                  valid_o,
    output logic      [WIDTH-1:0] data_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    logic [WIDTH-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0] r_wptr;
    logic [PTR_W-1:0] r_rptr;
    logic [PTR_W:0]   r_count;

    logic s_push;
    logic s_pop;

    assign full_o  = (r_count == (PTR_W+1)'(FIFO_DEPTH));
    assign valid_o = (r_count != '0);
    assign data_o  = mem[r_rptr];

    assign s_pop  = pop_i && valid_o;
    assign s_push = push_i && (!full_o || s_pop);  // full is fine when a pop frees a slot

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            r_wptr  <= '0;
            r_rptr  <= '0;
            r_count <= '0;
        end
        else
        begin
            if (s_push)
                r_wptr <= (r_wptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : r_wptr + 1'b1;
            if (s_pop)
                r_rptr <= (r_rptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : r_rptr + 1'b1;
            case ({s_push, s_pop})
                2'b10:   r_count <= r_count + 1'b1;
                2'b01:   r_count <= r_count - 1'b1;
                default: r_count <= r_count;
            endcase
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (s_push)
            mem[r_wptr] <= data_i;
    end

endmodule

`default_nettype wire

// File: design/udma_rx_addrgen.sv
`default_nettype none
`timescale 1ns/100ps

module udma_rx_addrgen
    import udma_rx_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rstn_i,
    input  wire addr_t       cfg_startaddr_i,
    input  wire trans_size_t cfg_size_i,
    input  wire logic        cfg_en_i,
    input  wire dsize_t      datasize_i,
    input  wire logic        take_i,
    output addr_t            curr_addr_o,
    output nbytes_t          nbytes_o,
    output logic             active_o,
    output logic             eot_o
);

    addr_t       r_addr;
    trans_size_t r_count;    // bytes still to move
    logic        r_en;
    logic        r_eot;

    logic [2:0]  s_size_bytes;
    logic [2:0]  s_step;     // bytes carried by the next word

    always_comb
    begin
        case (datasize_i)
            2'd0:    s_size_bytes = 3'd1;
            2'd1:    s_size_bytes = 3'd2;
            default: s_size_bytes = 3'd4;
        endcase

        // last word of a transfer may be short
        if (r_count < trans_size_t'(s_size_bytes))
            s_step = r_count[2:0];
        else
            s_step = s_size_bytes;
    end

    assign curr_addr_o = r_addr;
    assign nbytes_o    = nbytes_t'(s_step - 3'd1);
    assign active_o    = r_en;
    assign eot_o       = r_eot;

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            r_count <= '0;
            r_en    <= 1'b0;
            r_eot   <= 1'b0;
        end
        else
        begin
            r_eot <= 1'b0;
            if (cfg_en_i)
            begin
                r_count <= cfg_size_i;
                r_en    <= (cfg_size_i != '0);
            end
            else if (take_i && r_en)
            begin
                r_count <= r_count - trans_size_t'(s_step);
                if (r_count == trans_size_t'(s_step))
                begin
                    r_en  <= 1'b0;
                    r_eot <= 1'b1;  // one cycle after the last handshake
                end
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (cfg_en_i)
            r_addr <= cfg_startaddr_i;
        else if (take_i && r_en)
            r_addr <= r_addr + addr_t'(s_step);
    end

endmodule

`default_nettype wire

// File: design/udma_rx_arbiter.sv
`default_nettype none
`timescale 1ns/100ps

module udma_rx_arbiter
#(
    parameter int N_CHANNELS = 4
)
(
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,
    input  wire logic [N_CHANNELS-1:0] req_i,
    input  wire logic                  ack_i,
    output logic      [N_CHANNELS-1:0] grant_o,
    output logic                       any_grant_o
);

    localparam int PTR_W = (N_CHANNELS > 1) ? $clog2(N_CHANNELS) : 1;

    logic [PTR_W-1:0] r_ptr;     // highest priority channel
    logic [PTR_W-1:0] s_winner;

    // first requester at or after the pointer
    always_comb
    begin
        int idx;
        grant_o     = '0;
        any_grant_o = 1'b0;
        s_winner    = r_ptr;
        for (int i = 0; i < N_CHANNELS; i++)
        begin
            idx = (int'(r_ptr) + i) % N_CHANNELS;
            if (!any_grant_o && req_i[idx])
            begin
                grant_o[idx] = 1'b1;
                any_grant_o  = 1'b1;
                s_winner     = PTR_W'(idx);
            end
        end
    end

    // move past the winner only once it is taken, a stalled grant stays
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            r_ptr <= '0;
        else if (ack_i && any_grant_o)
        begin
            if (s_winner == PTR_W'(N_CHANNELS - 1))
                r_ptr <= '0;
            else
                r_ptr <= s_winner + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/udma_rx_pkg.sv
`default_nettype none

package udma_rx_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    parameter int L2_AWIDTH = 16;  // channel relative address

    typedef logic [L2_AWIDTH-1:0]    addr_t;        // byte address inside a region
    typedef logic [15:0]             trans_size_t;  // transfer byte count
    typedef logic [31:0]             data_t;
    typedef logic [3:0]              be_t;
    typedef logic [1:0]              dsize_t;       // 0 byte, 1 halfword, 2 word
    typedef logic [1:0]              dest_t;
    typedef logic [1:0]              nbytes_t;      // valid bytes minus one
    typedef logic [31:0]             bus_addr_t;
    typedef logic [31-L2_AWIDTH:0]   prefix_t;      // custom prefix of region 3

    // one queued write: {dest, nbytes, addr, data}
    localparam int RX_ENTRY_W = $bits(dest_t) + $bits(nbytes_t) + L2_AWIDTH + $bits(data_t);

    //////////////////////////////////////////////////////////////////////
    // region prefixes
    //////////////////////////////////////////////////////////////////////

    localparam logic [7:0]  PREFIX_L2      = 8'h1C;
    localparam logic [11:0] PREFIX_PERIPH  = 12'h1A1;
    localparam logic [7:0]  PREFIX_CLUSTER = 8'h10;

    // split of a write that crosses a word boundary
    typedef enum logic
    {
        RX_IDLE,
        RX_NON_ALIGNED
    } rx_state_e;

endpackage

`default_nettype wire
